/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // bus and pipeline word types
  typedef logic [63:0] addr_t;     // byte address, also the pc
  typedef logic [63:0] line_t;     // one memory word = one cache line
  typedef logic [31:0] inst_t;     // single instruction
  typedef logic [3:0]  mem_tag_t;  // 0 means no transaction
  typedef logic [1:0]  bus_cmd_t;

  // memory bus commands
  localparam bus_cmd_t BUS_NONE = 2'h0;
  localparam bus_cmd_t BUS_LOAD = 2'h1;

  // default sizes, both powers of two
  localparam int DEF_CACHE_LINES = 32;
  localparam int DEF_FB_DEPTH    = 8;

  // icache miss handling
  typedef enum logic [1:0] {
    IDLE,       // hits pass through, a miss issues the load at once
    REQUEST,    // load was refused, retry the latched line
    WAIT_DATA   // load accepted, waiting for the tag to come back
  } icache_state_e;

endpackage

`default_nettype wire

/* design/cachemem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cachemem_if import fetch_pkg::*; #(
  parameter int CACHE_LINES = DEF_CACHE_LINES
) ();

  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = 64 - 3 - IDX_W;

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  line_t            rd_data;
  logic             rd_hit;
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  line_t            wr_data;

  modport ctrl (output rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data, input rd_data, rd_hit);
  modport mem  (input rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data, output rd_data, rd_hit);

endinterface

`default_nettype wire

/* design/fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import fetch_pkg::*; ();

  logic  push;      // pair valid this cycle
  addr_t pc;        // pc of inst_0
  inst_t inst_0;
  inst_t inst_1;    // at pc + 4
  logic  fetch_en;  // buffer has room

  modport src (
    output push, pc, inst_0, inst_1,
    input  fetch_en
  );

  modport dst (
    input  push, pc, inst_0, inst_1,
    output fetch_en
  );

endinterface

`default_nettype wire

/* design/icache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem import fetch_pkg::*; #(
  parameter int CACHE_LINES = DEF_CACHE_LINES
) (
  input  logic        clock,
  input  logic        rst_n,
  cachemem_if.mem     cif
);

  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = 64 - 3 - IDX_W;

  line_t            data_mem [CACHE_LINES];
  logic [TAG_W-1:0] tag_mem  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid;

  // only the valid bits need clearing
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (cif.wr_en) begin
      valid[cif.wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (cif.wr_en) begin
      data_mem[cif.wr_idx] <= cif.wr_data;
      tag_mem[cif.wr_idx]  <= cif.wr_tag;
    end
  end

  // zero latency lookup
  assign cif.rd_data = data_mem[cif.rd_idx];
  assign cif.rd_hit  = valid[cif.rd_idx] && (tag_mem[cif.rd_idx] == cif.rd_tag);

endmodule

`default_nettype wire

/* design/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import fetch_pkg::*; #(
  parameter int CACHE_LINES = DEF_CACHE_LINES
) (
  input  logic     clock,
  input  logic     rst_n,
  input  addr_t    fetch_addr,
  input  mem_tag_t mem2proc_response,
  input  mem_tag_t mem2proc_tag,
  input  line_t    mem2proc_data,
  output bus_cmd_t proc2mem_command,
  output addr_t    proc2mem_addr,
  output line_t    line_data,
  output logic     line_valid,
  cachemem_if.ctrl cif
);

  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = 64 - 3 - IDX_W;

  icache_state_e    state, state_nxt;
  logic [IDX_W-1:0] cur_idx, miss_idx;
  logic [TAG_W-1:0] cur_tag, miss_tag;
  mem_tag_t         pend_tag;   // tag of the outstanding load
  logic             live;       // low until the first edge out of reset
  logic             miss;
  logic             accepted;
  logic             fill;

  // direct mapped split, 8 byte lines
  assign cur_idx = fetch_addr[IDX_W+2:3];
  assign cur_tag = fetch_addr[63:IDX_W+3];

  assign cif.rd_idx = cur_idx;
  assign cif.rd_tag = cur_tag;
  assign line_data  = cif.rd_data;
  assign line_valid = cif.rd_hit;   // hits pass straight through

  assign miss = live && (state == IDLE) && !cif.rd_hit;

  // a new miss goes out in the same cycle, a refused one is replayed from the latch
  assign proc2mem_command = (miss || state == REQUEST) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = (state == REQUEST) ? {miss_tag, miss_idx, 3'b000}
                                               : {fetch_addr[63:3], 3'b000};

  assign accepted = (proc2mem_command == BUS_LOAD) && (mem2proc_response != '0);
  assign fill     = (state == WAIT_DATA) && (mem2proc_tag == pend_tag);

  // fill goes to the latched line even if fetch has moved on
  assign cif.wr_en   = fill;
  assign cif.wr_idx  = miss_idx;
  assign cif.wr_tag  = miss_tag;
  assign cif.wr_data = mem2proc_data;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (miss) state_nxt = accepted ? WAIT_DATA : REQUEST;
      REQUEST:   if (accepted) state_nxt = WAIT_DATA;
      WAIT_DATA: if (fill) state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      live     <= 1'b0;
      pend_tag <= '0;
    end else begin
      state <= state_nxt;
      live  <= 1'b1;
      if (accepted) pend_tag <= mem2proc_response;
    end
  end

  // missing line, held until the fill
  always_ff @(posedge clock) begin
    if (miss) begin
      miss_idx <= cur_idx;
      miss_tag <= cur_tag;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import fetch_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,
  input  logic    redirect_en,
  input  addr_t   redirect_pc,
  input  line_t   line_data,
  input  logic    line_valid,
  output addr_t   fetch_addr,
  fetch_if.src    fif
);

  addr_t pc;

  // pc is always line aligned, so it doubles as the line address
  assign fetch_addr = pc;

  // low word sits at pc, high word at pc + 4
  assign fif.pc     = pc;
  assign fif.inst_0 = line_data[31:0];
  assign fif.inst_1 = line_data[63:32];
  assign fif.push   = line_valid && fif.fetch_en;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect_en) begin
      pc <= {redirect_pc[63:3], 3'b000};  // redirect wins over advance
    end else if (fif.push) begin
      pc <= pc + 64'd8;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import fetch_pkg::*; #(
  parameter int FB_DEPTH = DEF_FB_DEPTH
) (
  input  logic   clock,
  input  logic   rst_n,
  input  logic   redirect_en,
  input  logic   dispatch_en,
  output logic   inst_valid,
  output addr_t  inst_pc,
  output inst_t  inst_0,
  output inst_t  inst_1,
  fetch_if.dst   fif
);

  localparam int PTR_W = $clog2(FB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  addr_t pc_q [FB_DEPTH];
  inst_t i0_q [FB_DEPTH];
  inst_t i1_q [FB_DEPTH];

  logic [PTR_W-1:0] head, tail;
  logic [CNT_W-1:0] count;
  logic             do_push, do_pop;

  assign fif.fetch_en = (count != CNT_W'(FB_DEPTH));
  assign inst_valid   = (count != '0);

  assign do_push = fif.push && fif.fetch_en && !redirect_en;  // flush drops the push
  assign do_pop  = dispatch_en && inst_valid;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (redirect_en) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) tail <= tail + 1'b1;   // wraps, depth is a power of two
      if (do_pop)  head <= head + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      pc_q[tail] <= fif.pc;
      i0_q[tail] <= fif.inst_0;
      i1_q[tail] <= fif.inst_1;
    end
  end

  // head entry straight out
  assign inst_pc = pc_q[head];
  assign inst_0  = i0_q[head];
  assign inst_1  = i1_q[head];

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
  parameter int CACHE_LINES = DEF_CACHE_LINES,
  parameter int FB_DEPTH    = DEF_FB_DEPTH
) (
  input  logic     clock,
  input  logic     rst_n,
  input  mem_tag_t mem2proc_response,  // tag for the current request, 0 = refused
  input  mem_tag_t mem2proc_tag,       // tag of the returning line
  input  line_t    mem2proc_data,
  input  logic     redirect_en,
  input  addr_t    redirect_pc,
  input  logic     dispatch_en,
  output bus_cmd_t proc2mem_command,
  output addr_t    proc2mem_addr,
  output logic     inst_valid,
  output addr_t    inst_pc,
  output inst_t    inst_0,
  output inst_t    inst_1
);

  addr_t fetch_addr;
  line_t line_data;
  logic  line_valid;

  cachemem_if #(.CACHE_LINES(CACHE_LINES)) cmem_bus ();
  fetch_if                                 fetch_bus ();

  icache_mem #(.CACHE_LINES(CACHE_LINES)) i_icache_mem (
    .clock (clock),
    .rst_n (rst_n),
    .cif   (cmem_bus.mem)
  );

  icache_ctrl #(.CACHE_LINES(CACHE_LINES)) i_icache_ctrl (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_addr        (fetch_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .line_data         (line_data),
    .line_valid        (line_valid),
    .cif               (cmem_bus.ctrl)
  );

  fetch_stage i_fetch_stage (
    .clock       (clock),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .line_data   (line_data),
    .line_valid  (line_valid),
    .fetch_addr  (fetch_addr),
    .fif         (fetch_bus.src)
  );

  fetch_buffer #(.FB_DEPTH(FB_DEPTH)) i_fetch_buffer (
    .clock       (clock),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .dispatch_en (dispatch_en),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst_0      (inst_0),
    .inst_1      (inst_1),
    .fif         (fetch_bus.dst)
  );

endmodule

`default_nettype wire

/* tb/fetch_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assert import fetch_pkg::*; (
  input logic     clock,
  input logic     rst_n,
  input bus_cmd_t proc2mem_command,
  input addr_t    proc2mem_addr,
  input logic     inst_valid
);

  // only the two defined commands
  cmd_legal: assert property (@(posedge clock) disable iff (!rst_n)
    (proc2mem_command == BUS_NONE) || (proc2mem_command == BUS_LOAD))
    else $error("proc2mem_command %h is not a bus command", proc2mem_command);

  quiet_in_reset: assert property (@(posedge clock)
    !rst_n |-> (!inst_valid && proc2mem_command == BUS_NONE))
    else $error("inst_valid or proc2mem_command active while rst_n is low");

  load_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    (proc2mem_command == BUS_LOAD) |-> (proc2mem_addr[2:0] == 3'b000))
    else $error("BUS_LOAD to unaligned address %h", proc2mem_addr);  // lines are 8 bytes

endmodule

bind fetch_unit fetch_unit_assert i_fetch_unit_assert (
  .clock            (clock),
  .rst_n            (rst_n),
  .proc2mem_command (proc2mem_command),
  .proc2mem_addr    (proc2mem_addr),
  .inst_valid       (inst_valid)
);

`default_nettype wire

/* tb/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit import fetch_pkg::*; ();

  localparam int    CACHE_LINES  = 32;
  localparam int    FB_DEPTH     = 8;
  localparam inst_t INST_PATTERN = 32'h9e37_79b9;
  localparam int    TOTAL_POPS   = 40 + 40 + 30 + 24 + 12;  // pops over all tests
  localparam int    STALL_CYCLES = 120;
  localparam int    WORST_MISS   = 16;  // request, a few refusals, 8 cycle return
  localparam int    MARGIN       = 4;
  localparam int    WATCHDOG_NS  = (TOTAL_POPS * WORST_MISS * MARGIN + STALL_CYCLES) * 10;

  logic     clock;
  logic     rst_n;
  logic     redirect_en;
  logic     dispatch_en;
  addr_t    redirect_pc;
  mem_tag_t mem2proc_response;
  mem_tag_t mem2proc_tag;
  line_t    mem2proc_data;
  bus_cmd_t proc2mem_command;
  addr_t    proc2mem_addr;
  logic     inst_valid;
  addr_t    inst_pc;
  inst_t    inst_0;
  inst_t    inst_1;

  integer   seed = 32'hdbc51f8a;
  int       errors = 0;
  int       checks = 0;
  int       pop_count = 0;
  int       refusals = 0;
  int       cycle = 0;
  addr_t    exp_pc = '0;         // pc of the next pair to be popped
  addr_t    max_req_addr = '0;
  addr_t    req_log[$];          // every BUS_LOAD address, in order
  mem_tag_t ret_tag[$];
  addr_t    ret_addr[$];
  int       ret_due[$];

  fetch_unit #(.CACHE_LINES(CACHE_LINES), .FB_DEPTH(FB_DEPTH)) i_fetch_unit (.*);

  // memory image, pattern xor the low address word
  function automatic inst_t exp_inst(input addr_t a);
    return INST_PATTERN ^ a[31:0];
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input string name, input bus_cmd_t got, input bus_cmd_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("test %s done, %0d errors", name, errors - err0);
  endtask

  // pops n pairs, throttled leaves every third cycle idle
  task automatic run_pops(input int n, input bit throttled);
    int target;
    int k;
    target = pop_count + n;
    k = 0;
    while (pop_count < target) begin
      @(negedge clock);
      dispatch_en = throttled ? (k % 3 != 2) : 1'b1;
      k++;
    end
    dispatch_en = 1'b0;
  endtask

  task automatic do_redirect(input addr_t target);
    @(negedge clock);
    dispatch_en = 1'b0;
    redirect_en = 1'b1;
    redirect_pc = target;
    @(negedge clock);
    redirect_en = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // memory model, one in four loads refused, data back 1 to 8 cycles later
  initial begin : memory_model
    addr_t    a;
    mem_tag_t next_tag;
    logic     was_refused;
    addr_t    refused_addr;
    next_tag = 4'd1;
    was_refused = 1'b0;
    refused_addr = '0;
    mem2proc_response = '0;
    mem2proc_tag = '0;
    mem2proc_data = '0;
    forever begin
      @(negedge clock);
      cycle++;
      mem2proc_response = '0;
      mem2proc_tag = '0;
      if (ret_tag.size() != 0 && ret_due[0] <= cycle) begin
        a = ret_addr.pop_front();
        mem2proc_tag = ret_tag.pop_front();
        mem2proc_data = {exp_inst(a + 64'd4), exp_inst(a)};
        ret_due.delete(0);
      end
      if (was_refused) begin  // same line again, one cycle later
        check_cmd("proc2mem_command", proc2mem_command, BUS_LOAD);
        check_addr("proc2mem_addr", proc2mem_addr, refused_addr);
      end
      was_refused = 1'b0;
      if (proc2mem_command == BUS_LOAD) begin
        req_log.push_back(proc2mem_addr);
        if (proc2mem_addr > max_req_addr) max_req_addr = proc2mem_addr;
        if ({$random(seed)} % 4 == 0) begin
          refusals++;
          was_refused = 1'b1;
          refused_addr = proc2mem_addr;
        end else begin
          mem2proc_response = next_tag;
          ret_tag.push_back(next_tag);
          ret_addr.push_back(proc2mem_addr);
          ret_due.push_back(cycle + 1 + int'({$random(seed)} % 8));
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
    end
  end

  // every pop is compared with the tracked pc
  initial begin : compare_pops
    forever begin
      @(posedge clock);
      if (rst_n && redirect_en) begin
        exp_pc = redirect_pc & ~addr_t'(7);
      end else if (rst_n && inst_valid && dispatch_en) begin
        check_addr("inst_pc", inst_pc, exp_pc);
        check_inst("inst_0", inst_0, exp_inst(exp_pc));
        check_inst("inst_1", inst_1, exp_inst(exp_pc + 64'd4));
        exp_pc = exp_pc + 64'd8;
        pop_count++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the fetch stream stopped making progress", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int    err0;
    int    refusals0;
    int    snap;
    addr_t floor_addr;
    addr_t back_pc;
    rst_n = 1'b1;
    redirect_en = 1'b0;
    redirect_pc = '0;
    dispatch_en = 1'b0;
    err0 = errors;
    #1;
    rst_n = 1'b0;
    repeat (2) begin
      @(negedge clock);
      check_flag("inst_valid", inst_valid, 1'b0);
      check_cmd("proc2mem_command", proc2mem_command, BUS_NONE);
    end
    rst_n = 1'b1;
    @(posedge clock);
    check_flag("inst_valid", inst_valid, 1'b0);
    check_cmd("proc2mem_command", proc2mem_command, BUS_NONE);
    @(negedge clock);  // first miss goes out at pc 0
    check_cmd("proc2mem_command", proc2mem_command, BUS_LOAD);
    check_addr("proc2mem_addr", proc2mem_addr, '0);
    finish_test("reset", err0);

    err0 = errors;
    run_pops(40, 1'b0);
    finish_test("sequential stream", err0);

    err0 = errors;
    refusals0 = refusals;
    run_pops(40, 1'b1);
    if (refusals == refusals0) report_failure("the memory model refused no request in this test");
    finish_test("refused requests", err0);

    err0 = errors;
    floor_addr = exp_pc + addr_t'(8 * FB_DEPTH);  // pc once the buffer is full
    repeat (STALL_CYCLES) @(negedge clock);
    check_addr("max proc2mem_addr", max_req_addr, floor_addr);
    run_pops(30, 1'b0);
    finish_test("back-pressure", err0);

    err0 = errors;
    back_pc = exp_pc - 64'd128;  // 16 lines back, all still cached
    @(posedge clock);
    snap = req_log.size();
    floor_addr = max_req_addr;
    do_redirect(back_pc);
    run_pops(24, 1'b0);
    for (int i = snap; i < req_log.size(); i++) begin
      if (req_log[i] < floor_addr) begin
        report_failure($sformatf("a BUS_LOAD went to %h, a line already in the cache",
                                 req_log[i]));
      end
    end
    finish_test("redirect and cache hits", err0);

    err0 = errors;
    dispatch_en = 1'b1;
    @(posedge clock);
    while (ret_tag.size() == 0) @(posedge clock);  // a fill is pending
    do_redirect(64'h0000_0004_0000_1005);
    run_pops(12, 1'b0);
    finish_test("redirect during a miss", err0);

    $display("tests run 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
design/fetch_pkg.sv
design/cachemem_if.sv
design/fetch_if.sv
design/icache_mem.sv
design/icache_ctrl.sv
design/fetch_stage.sv
design/fetch_buffer.sv
design/fetch_unit.sv
tb/fetch_unit_assert.sv
tb/tb_fetch_unit.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_fetch_unit
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
